// ==== source/polar_defines.svh ====
`ifndef POLAR_DEFINES_SVH
`define POLAR_DEFINES_SVH

// Wishbone side
`define POLAR_DAT_W 32
`define POLAR_ADR_W 3

// Result queue
`define POLAR_FIFO_DEPTH 4
`define POLAR_PTR_W 2
`define POLAR_CNT_W 3

// Core sequencing, cycles spent in ST_RUN
`define POLAR_RUN_CYCLES 8

// Tangent table, Q8.8 entries for 1..89 degrees
`define POLAR_TAN_W 16
`define POLAR_TAN_MAX 89

`endif

// ==== source/polar_pkg.sv ====
`include "polar_defines.svh"

package polar_pkg;

    typedef logic [7:0] coord_t;      // Unsigned coordinate, also r and theta
    typedef logic [15:0] radicand_t;  // x*x + y*y, kept modulo 2^16

    // Packed result as it sits in the queue
    typedef struct packed {
        coord_t z;      // 23:16
        coord_t theta;  // 15:8
        coord_t r;      // 7:0
    } polar_word_t;

    // Word addresses on the Wishbone port
    typedef enum logic [`POLAR_ADR_W-1:0] {
        REG_X      = 3'd0,
        REG_Y      = 3'd1,
        REG_Z      = 3'd2,
        REG_CTRL   = 3'd3,  // Bit 0 requests a conversion
        REG_STATUS = 3'd4,
        REG_RESULT = 3'd5   // Read pops the queue
    } wb_reg_e;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_RUN,
        ST_PUSH
    } polar_state_e;

endpackage

// ==== source/wb_polar_regs.sv ====
`timescale 1ns/10ps
`include "polar_defines.svh"

module wb_polar_regs (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       cyc,
    input  logic                       stb,
    input  logic                       we,
    input  logic [`POLAR_ADR_W-1:0]    adr,
    input  logic [`POLAR_DAT_W-1:0]    dat_w,
    output logic [`POLAR_DAT_W-1:0]    dat_r,
    output logic                       ack,
    output polar_pkg::coord_t          x,
    output polar_pkg::coord_t          y,
    output polar_pkg::coord_t          z,
    output logic                       start_req,
    input  logic                       start_ack,
    input  logic                       busy,
    output logic                       pop,
    input  polar_pkg::polar_word_t     pop_data,
    input  logic                       empty,
    input  logic                       full,
    input  logic [`POLAR_CNT_W-1:0]    count
);
    import polar_pkg::*;

    wb_reg_e                 reg_sel;
    logic                    acc;      // Cycle accepted and ack follows
    logic                    wr_acc;
    logic                    pending;  // Start requested but not yet taken by the core
    logic [`POLAR_DAT_W-1:0] rd_mux;

    assign reg_sel   = wb_reg_e'(adr);
    assign acc       = cyc && stb && !ack;  // One ack per access
    assign wr_acc    = acc && we;
    assign start_req = pending;

    // Pop on the acking edge and never on an empty queue
    assign pop = acc && !we && (reg_sel == REG_RESULT) && !empty;

    // Read data with unused bits at 0
    always_comb begin
        rd_mux = '0;
        case (reg_sel)
            REG_X:      rd_mux[7:0] = x;
            REG_Y:      rd_mux[7:0] = y;
            REG_Z:      rd_mux[7:0] = z;
            REG_STATUS: rd_mux[6:0] = {count, pending, full, !empty, busy};
            REG_RESULT: begin
                if (!empty) begin
                    rd_mux[23:0] = pop_data;  // FWFT head
                end
            end
            default:    rd_mux = '0;  // CTRL and 6..7 read as 0
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ack     <= 1'b0;
            dat_r   <= '0;
            x       <= '0;
            y       <= '0;
            z       <= '0;
            pending <= 1'b0;
        end else begin
            ack <= acc;
            if (acc) begin
                dat_r <= we ? '0 : rd_mux;
            end
            if (wr_acc) begin
                case (reg_sel)
                    REG_X:   x <= dat_w[7:0];
                    REG_Y:   y <= dat_w[7:0];
                    REG_Z:   z <= dat_w[7:0];
                    default: ;  // CTRL is handled below and the rest is read only
                endcase
            end
            // The core taking the request wins over a repeated start
            if (start_ack) begin
                pending <= 1'b0;
            end else if (wr_acc && (reg_sel == REG_CTRL) && dat_w[0]) begin
                pending <= 1'b1;
            end
        end
    end

    // The core only takes a request that is pending
    a_ack_pending: assert property (@(posedge clk) disable iff (!rst_n)
        start_ack |-> pending);

endmodule

// ==== source/isqrt_unit.sv ====
`timescale 1ns/10ps

module isqrt_unit (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  start,
    input  polar_pkg::radicand_t  radicand,
    output polar_pkg::coord_t     root
);
    import polar_pkg::*;

    radicand_t  rad_q;
    coord_t     root_q;
    logic [2:0] idx_q;     // Next root bit to try
    logic       active;
    radicand_t  rad_cur;
    coord_t     root_cur;
    coord_t     trial;
    logic [2:0] idx_cur;
    logic       keep;

    // Start edge already resolves bit 7, so eight edges in all
    always_comb begin
        rad_cur  = start ? radicand : rad_q;
        root_cur = start ? '0 : root_q;
        idx_cur  = start ? 3'd7 : idx_q;
        trial    = root_cur | coord_t'(8'd1 << idx_cur);
        keep     = (radicand_t'(trial) * radicand_t'(trial)) <= rad_cur;  // 255^2 fits
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            active <= 1'b0;
            idx_q  <= '0;
        end else if (start || active) begin
            active <= (idx_cur != 3'd0);  // Stop after bit 0
            idx_q  <= idx_cur - 3'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            rad_q <= radicand;
        end
        if (start || active) begin
            root_q <= keep ? trial : root_cur;
        end
    end

    assign root = root_q;

    // Floor property once all bits are in, radicand held by the core
    a_root_floor: assert property (@(posedge clk) disable iff (!rst_n)
        start |-> ##8 ((radicand_t'(root) * radicand_t'(root)) <= radicand));

endmodule

// ==== source/atan_search.sv ====
`timescale 1ns/10ps
`include "polar_defines.svh"

module atan_search (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               start,
    input  polar_pkg::coord_t  x,
    input  polar_pkg::coord_t  y,
    output polar_pkg::coord_t  theta
);
    import polar_pkg::*;

    // round(tan(a deg) * 256), entry 0 unused
    localparam logic [`POLAR_TAN_W-1:0] TAN_TBL [0:`POLAR_TAN_MAX] = '{
        16'd0,    16'd4,    16'd9,    16'd13,   16'd18,   16'd22,   16'd27,   16'd31,
        16'd36,   16'd41,   16'd45,   16'd50,   16'd54,   16'd59,   16'd64,   16'd69,
        16'd73,   16'd78,   16'd83,   16'd88,   16'd93,   16'd98,   16'd103,  16'd109,
        16'd114,  16'd119,  16'd125,  16'd130,  16'd136,  16'd142,  16'd148,  16'd154,
        16'd160,  16'd166,  16'd173,  16'd179,  16'd186,  16'd193,  16'd200,  16'd207,
        16'd215,  16'd223,  16'd231,  16'd239,  16'd247,  16'd256,  16'd265,  16'd275,
        16'd284,  16'd294,  16'd305,  16'd316,  16'd328,  16'd340,  16'd352,  16'd366,
        16'd380,  16'd394,  16'd410,  16'd426,  16'd443,  16'd462,  16'd481,  16'd502,
        16'd525,  16'd549,  16'd575,  16'd603,  16'd634,  16'd667,  16'd703,  16'd743,
        16'd788,  16'd837,  16'd893,  16'd955,  16'd1027, 16'd1109, 16'd1204, 16'd1317,
        16'd1452, 16'd1616, 16'd1822, 16'd2085, 16'd2436, 16'd2926, 16'd3661, 16'd4885,
        16'd7331, 16'd14666
    };

    coord_t                  x_q;
    coord_t                  y_q;
    coord_t                  x_cur;
    coord_t                  y_cur;
    logic [6:0]              ang_q;    // Angles counted so far
    logic [6:0]              ang_cur;
    logic [6:0]              cand;
    logic [2:0]              idx_q;
    logic [2:0]              idx_cur;
    logic                    active;
    logic                    keep;
    logic [`POLAR_TAN_W-1:0] tan_val;
    logic [`POLAR_TAN_W+7:0] lhs;      // T[a] * x, up to 24 bits

    // One answer bit per edge, 64 down to 1, start edge included
    always_comb begin
        x_cur   = start ? x : x_q;
        y_cur   = start ? y : y_q;
        ang_cur = start ? '0 : ang_q;
        idx_cur = start ? 3'd6 : idx_q;
        cand    = ang_cur | (7'd1 << idx_cur);
        tan_val = TAN_TBL[(cand > `POLAR_TAN_MAX) ? `POLAR_TAN_MAX : cand];
        lhs     = tan_val * x_cur;
        keep    = (cand <= `POLAR_TAN_MAX) && (lhs <= {y_cur, 8'd0});  // T[a]*x <= y*256
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            active <= 1'b0;
            idx_q  <= '0;
        end else if (start || active) begin
            active <= (idx_cur != 3'd0);
            idx_q  <= idx_cur - 3'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            x_q <= x;
            y_q <= y;
        end
        if (start || active) begin
            ang_q <= keep ? cand : ang_cur;
        end
    end

    // x of 0 gives 90 for any y above 0
    assign theta = (x_q != '0) ? coord_t'(ang_q) :
                   (y_q != '0) ? coord_t'(`POLAR_TAN_MAX + 1) : '0;

endmodule

// ==== source/result_fifo.sv ====
`timescale 1ns/10ps
`include "polar_defines.svh"

module result_fifo (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     push,
    input  polar_pkg::polar_word_t   push_data,
    input  logic                     pop,
    output polar_pkg::polar_word_t   pop_data,
    output logic                     empty,
    output logic                     full,
    output logic [`POLAR_CNT_W-1:0]  count
);
    import polar_pkg::*;

    polar_word_t             mem [`POLAR_FIFO_DEPTH];
    logic [`POLAR_PTR_W-1:0] wr_ptr;   // Wraps with the depth of 4
    logic [`POLAR_PTR_W-1:0] rd_ptr;
    logic                    do_push;
    logic                    do_pop;

    assign do_pop  = pop && !empty;
    assign do_push = push && (!full || do_pop);  // Push and pop on full is fine

    assign empty    = (count == '0);
    assign full     = (count == `POLAR_CNT_W'(`POLAR_FIFO_DEPTH));
    assign pop_data = mem[rd_ptr];  // Head visible before the pop

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    // Register block must not pop an empty queue
    a_no_pop_empty: assert property (@(posedge clk) disable iff (!rst_n)
        !(pop && empty));

endmodule

// ==== source/polar_core.sv ====
`timescale 1ns/10ps
`include "polar_defines.svh"

module polar_core (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    start_req,
    input  polar_pkg::coord_t       x,
    input  polar_pkg::coord_t       y,
    input  polar_pkg::coord_t       z,
    output logic                    start_ack,
    output logic                    busy,
    output logic                    push,
    output polar_pkg::polar_word_t  push_data,
    input  logic                    full
);
    import polar_pkg::*;

    polar_state_e state;
    logic [2:0]   run_cnt;   // Cycles spent in ST_RUN
    logic         run_last;
    logic         unit_start;
    coord_t       x_q;
    coord_t       y_q;
    coord_t       z_q;       // Passed through untouched
    radicand_t    radicand;
    coord_t       root;
    coord_t       theta;

    assign start_ack  = (state == ST_IDLE) && start_req;
    assign busy       = (state != ST_IDLE);
    assign run_last   = (run_cnt == 3'(`POLAR_RUN_CYCLES - 1));
    assign unit_start = (state == ST_RUN) && (run_cnt == '0);  // Both units together
    assign push       = (state == ST_PUSH) && !full;           // Wait for room

    // Sum of squares drops the top bit of the 17-bit sum
    assign radicand = radicand_t'(({8'd0, x_q} * {8'd0, x_q}) + ({8'd0, y_q} * {8'd0, y_q}));

    assign push_data.z     = z_q;
    assign push_data.theta = theta;
    assign push_data.r     = root;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state   <= ST_IDLE;
            run_cnt <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (start_req) begin
                        state   <= ST_RUN;
                        run_cnt <= '0;
                    end
                end
                ST_RUN: begin
                    run_cnt <= run_cnt + 3'd1;
                    if (run_last) begin
                        state <= ST_PUSH;  // Root and angle settled
                    end
                end
                ST_PUSH: begin
                    if (!full) begin
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Operands held until the next request is taken
    always_ff @(posedge clk) begin
        if (start_ack) begin
            x_q <= x;
            y_q <= y;
            z_q <= z;
        end
    end

    isqrt_unit isqrt_unit_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .start    (unit_start),
        .radicand (radicand),
        .root     (root)
    );

    atan_search atan_search_i (
        .clk   (clk),
        .rst_n (rst_n),
        .start (unit_start),
        .x     (x_q),
        .y     (y_q),
        .theta (theta)
    );

    // A pushed word is fully resolved and theta never tops 90
    a_push_valid: assert property (@(posedge clk) disable iff (!rst_n)
        push |-> !$isunknown(push_data) &&
                 (push_data.theta <= coord_t'(`POLAR_TAN_MAX + 1)));

endmodule

// ==== source/polar_top.sv ====
`timescale 1ns/10ps
`include "polar_defines.svh"

module polar_top (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    cyc,
    input  logic                    stb,
    input  logic                    we,
    input  logic [`POLAR_ADR_W-1:0] adr,
    input  logic [`POLAR_DAT_W-1:0] dat_w,
    output logic [`POLAR_DAT_W-1:0] dat_r,
    output logic                    ack
);

    // Register block to core
    polar_pkg::coord_t       x;
    polar_pkg::coord_t       y;
    polar_pkg::coord_t       z;
    logic                    start_req;
    logic                    start_ack;
    logic                    busy;

    // Core to queue, queue to register block
    logic                    push;
    polar_pkg::polar_word_t  push_data;
    logic                    pop;
    polar_pkg::polar_word_t  pop_data;
    logic                    empty;
    logic                    full;
    logic [`POLAR_CNT_W-1:0] count;

    wb_polar_regs wb_polar_regs_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .cyc       (cyc),
        .stb       (stb),
        .we        (we),
        .adr       (adr),
        .dat_w     (dat_w),
        .dat_r     (dat_r),
        .ack       (ack),
        .x         (x),
        .y         (y),
        .z         (z),
        .start_req (start_req),
        .start_ack (start_ack),
        .busy      (busy),
        .pop       (pop),
        .pop_data  (pop_data),
        .empty     (empty),
        .full      (full),
        .count     (count)
    );

    polar_core polar_core_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .start_req (start_req),
        .x         (x),
        .y         (y),
        .z         (z),
        .start_ack (start_ack),
        .busy      (busy),
        .push      (push),
        .push_data (push_data),
        .full      (full)
    );

    result_fifo result_fifo_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .push      (push),
        .push_data (push_data),
        .pop       (pop),
        .pop_data  (pop_data),
        .empty     (empty),
        .full      (full),
        .count     (count)
    );

endmodule

// ==== tests/tb_polar_top.sv ====
`timescale 1ns/10ps
`include "polar_defines.svh"

module tb_polar_top;
    import polar_pkg::*;

    localparam int  ACK_LIMIT  = 20;   // Cycles per bus access
    localparam int  POLL_LIMIT = 200;  // STATUS reads per wait
    localparam int  N_DIR      = 16;
    localparam int  N_RAND     = 200;
    localparam int  N_BP       = 6;    // Two more than the queue holds
    localparam real PI         = 3.14159265358979;

    typedef struct packed {
        coord_t      x;
        coord_t      y;
        coord_t      z;
        polar_word_t exp;  // Filled in by the model
    } vec_t;

    logic                    clk = 1'b0;
    logic                    rst_n;
    logic                    cyc;
    logic                    stb;
    logic                    we;
    logic [`POLAR_ADR_W-1:0] adr;
    logic [`POLAR_DAT_W-1:0] dat_w;
    logic [`POLAR_DAT_W-1:0] dat_r;
    logic                    ack;

    vec_t        dir_tbl [N_DIR];
    vec_t        bp_tbl [N_BP];
    int          tan_tbl [1:89];         // Q8.8 tangents for whole degrees
    logic [31:0] lfsr_state = 32'he51e;

    always #5 clk = ~clk;  // 10 ns period

    polar_top polar_top_i (
        .clk   (clk),
        .rst_n (rst_n),
        .cyc   (cyc),
        .stb   (stb),
        .we    (we),
        .adr   (adr),
        .dat_w (dat_w),
        .dat_r (dat_r),
        .ack   (ack)
    );

    // Fibonacci LFSR with taps 32 22 2 1
    function automatic logic lfsr_step();
        logic fb;
        fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        return fb;
    endfunction

    function automatic coord_t rand_coord();
        coord_t v;
        int     i;
        v = '0;
        for (i = 0; i < 8; i++) begin
            v = {v[6:0], lfsr_step()};  // One step per bit
        end
        return v;
    endfunction

    // Largest r with r*r not above the 16-bit radicand
    function automatic coord_t model_r(coord_t x, coord_t y);
        int xi;
        int yi;
        int rad;
        int r;
        xi  = x;
        yi  = y;
        rad = (xi * xi + yi * yi) % 65536;  // Radicand wraps at 16 bits
        r   = 0;
        while (r < 255 && (r + 1) * (r + 1) <= rad) begin
            r++;
        end
        return coord_t'(r);
    endfunction

    // Number of table angles at or below y/x
    function automatic coord_t model_theta(coord_t x, coord_t y);
        int cnt;
        int a;
        cnt = 0;
        if (x == 0) begin
            cnt = (y != 0) ? 90 : 0;
        end else begin
            for (a = 1; a <= 89; a++) begin
                if (tan_tbl[a] * int'(x) <= int'(y) * 256) begin
                    cnt++;
                end
            end
        end
        return coord_t'(cnt);
    endfunction

    function automatic polar_word_t model_word(coord_t x, coord_t y, coord_t z);
        polar_word_t w;
        w.z     = z;  // Passed through
        w.theta = model_theta(x, y);
        w.r     = model_r(x, y);
        return w;
    endfunction

    task automatic build_tan_table();
        int a;
        for (a = 1; a <= 89; a++) begin
            tan_tbl[a] = $rtoi($tan(a * PI / 180.0) * 256.0 + 0.5);  // Rounded
        end
    endtask

    task automatic set_dir(input int i, input coord_t x, input coord_t y, input coord_t z);
        dir_tbl[i].x   = x;
        dir_tbl[i].y   = y;
        dir_tbl[i].z   = z;
        dir_tbl[i].exp = model_word(x, y, z);
    endtask

    task automatic load_directed();
        set_dir(0, 8'd0, 8'd0, 8'h00);      // Origin
        set_dir(1, 8'd0, 8'd1, 8'h11);      // On the y axis
        set_dir(2, 8'd0, 8'd255, 8'h22);
        set_dir(3, 8'd1, 8'd0, 8'h33);      // On the x axis
        set_dir(4, 8'd255, 8'd0, 8'h44);
        set_dir(5, 8'd100, 8'd100, 8'h55);  // 45 degrees
        set_dir(6, 8'd255, 8'd255, 8'h66);  // Sum of squares wraps
        set_dir(7, 8'd3, 8'd4, 8'h77);      // Pythagorean triples
        set_dir(8, 8'd12, 8'd5, 8'h88);
        set_dir(9, 8'd120, 8'd160, 8'h99);
        set_dir(10, 8'd60, 8'd80, 8'haa);
        set_dir(11, 8'd1, 8'd255, 8'hbb);   // Steep
        set_dir(12, 8'd1, 8'd100, 8'hcc);
        set_dir(13, 8'd2, 8'd255, 8'hdd);
        set_dir(14, 8'd255, 8'd1, 8'hee);   // Shallow
        set_dir(15, 8'd7, 8'd255, 8'hff);
    endtask

    task automatic fail_stop(input string what);
        $display("%s", what);
        $display("SIMULATION FAILED");
        $fatal(1, "Stopped at first error");
    endtask

    task automatic check_word(input string name, input polar_word_t exp, input polar_word_t act);
        if (act !== exp) begin
            fail_stop($sformatf("FAILED at %0t ns: %s expected 'h%h got 'h%h",
                                $time, name, exp, act));
        end
    endtask

    task automatic check_coord(input string name, input coord_t exp, input coord_t act);
        if (act !== exp) begin
            fail_stop($sformatf("FAILED at %0t ns: %s expected 'h%h got 'h%h",
                                $time, name, exp, act));
        end
    endtask

    // Single STATUS field with flags zero-extended
    task automatic check_status(input string name, input logic [`POLAR_CNT_W-1:0] exp,
                                input logic [`POLAR_CNT_W-1:0] act);
        if (act !== exp) begin
            fail_stop($sformatf("FAILED at %0t ns: %s expected %0d got %0d",
                                $time, name, exp, act));
        end
    endtask

    task automatic check_data(input string name, input logic [`POLAR_DAT_W-1:0] exp,
                              input logic [`POLAR_DAT_W-1:0] act);
        if (act !== exp) begin
            fail_stop($sformatf("FAILED at %0t ns: %s expected 'h%h got 'h%h",
                                $time, name, exp, act));
        end
    endtask

    // Classic single access that drops stb right after ack
    task automatic wb_access(input logic wr, input logic [`POLAR_ADR_W-1:0] addr,
                             input logic [`POLAR_DAT_W-1:0] wdata,
                             output logic [`POLAR_DAT_W-1:0] rdata);
        int waited;
        @(negedge clk);
        cyc    = 1'b1;
        stb    = 1'b1;
        we     = wr;
        adr    = addr;
        dat_w  = wdata;
        waited = 0;
        do begin
            @(negedge clk);  // Outputs settled mid-cycle
            waited++;
        end while (!ack && waited < ACK_LIMIT);
        if (!ack) begin
            fail_stop($sformatf("Timeout: no ack for the access to address %0d", addr));
        end
        rdata = dat_r;
        cyc   = 1'b0;
        stb   = 1'b0;
        we    = 1'b0;
    endtask

    task automatic wb_write(input logic [`POLAR_ADR_W-1:0] addr,
                            input logic [`POLAR_DAT_W-1:0] data);
        logic [`POLAR_DAT_W-1:0] unused;
        wb_access(1'b1, addr, data, unused);
    endtask

    task automatic wb_read(input logic [`POLAR_ADR_W-1:0] addr,
                           output logic [`POLAR_DAT_W-1:0] data);
        wb_access(1'b0, addr, '0, data);
    endtask

    task automatic wait_status_bit(input int bit_idx, input logic val, input string what);
        logic [`POLAR_DAT_W-1:0] s;
        int                      polls;
        polls = 0;
        do begin
            wb_read(REG_STATUS, s);
            polls++;
        end while (s[bit_idx] !== val && polls < POLL_LIMIT);
        if (s[bit_idx] !== val) begin
            fail_stop($sformatf("Timeout: STATUS never showed %s", what));
        end
    endtask

    task automatic start_conv(input vec_t v);
        wb_write(REG_X, {24'h0, v.x});
        wb_write(REG_Y, {24'h0, v.y});
        wb_write(REG_Z, {24'h0, v.z});
        wb_write(REG_CTRL, 32'h1);
    endtask

    // Start, poll for a result, pop it
    task automatic run_single(input vec_t v, input string name);
        logic [`POLAR_DAT_W-1:0] rd;
        start_conv(v);
        wait_status_bit(1, 1'b1, "result available");
        wb_read(REG_RESULT, rd);
        check_word(name, v.exp, polar_word_t'(rd[23:0]));
        check_data($sformatf("%s upper bits", name), '0, {8'h0, rd[31:24]});
    endtask

    initial begin
        logic [`POLAR_DAT_W-1:0] rd;
        vec_t                    v;
        coord_t                  val;
        int                      i;
        rst_n = 1'b0;
        cyc   = 1'b0;
        stb   = 1'b0;
        we    = 1'b0;
        adr   = '0;
        dat_w = '0;
        build_tan_table();
        load_directed();
        repeat (5) @(negedge clk);
        rst_n = 1'b1;

        // Everything reads 0 out of reset and the empty queue pops nothing
        wb_read(REG_X, rd);
        check_data("x after reset", '0, rd);
        wb_read(REG_Y, rd);
        check_data("y after reset", '0, rd);
        wb_read(REG_Z, rd);
        check_data("z after reset", '0, rd);
        wb_read(REG_STATUS, rd);
        check_data("status after reset", '0, rd);
        wb_read(REG_RESULT, rd);
        check_data("result on empty queue", '0, rd);

        // Coordinate readback drops the upper write bits
        for (i = 0; i < 3; i++) begin
            val = coord_t'(8'h3c + i * 8'h55);
            wb_write(i, {24'hfeedbe, val});
            wb_read(i, rd);
            check_coord($sformatf("coordinate register %0d", i), val, rd[7:0]);
            check_data($sformatf("register %0d upper bits", i), '0, {8'h0, rd[31:8]});
        end

        for (i = 0; i < N_DIR; i++) begin
            run_single(dir_tbl[i], $sformatf("directed result %0d", i));
        end

        for (i = 0; i < N_RAND; i++) begin
            v.x   = rand_coord();
            v.y   = rand_coord();
            v.z   = rand_coord();
            v.exp = model_word(v.x, v.y, v.z);
            run_single(v, $sformatf("random result %0d", i));
        end

        // Back-pressure with four queued, one in the core and one pending
        for (i = 0; i < N_BP; i++) begin
            bp_tbl[i].x   = rand_coord();
            bp_tbl[i].y   = rand_coord();
            bp_tbl[i].z   = rand_coord();
            bp_tbl[i].exp = model_word(bp_tbl[i].x, bp_tbl[i].y, bp_tbl[i].z);
            wait_status_bit(3, 1'b0, "start pending cleared");
            start_conv(bp_tbl[i]);
        end
        wait_status_bit(2, 1'b1, "queue full");
        wb_read(REG_STATUS, rd);
        check_status("status count", 3'd4, rd[6:4]);
        check_status("status busy", 3'd1, {2'b0, rd[0]});
        check_status("status pending", 3'd1, {2'b0, rd[3]});

        // Repeat start while pending, then new operands before the core takes it
        wb_write(REG_CTRL, 32'h1);
        v.x   = 8'd200;
        v.y   = 8'd30;
        v.z   = 8'h5e;
        v.exp = model_word(v.x, v.y, v.z);
        wb_write(REG_X, {24'h0, v.x});
        wb_write(REG_Y, {24'h0, v.y});
        wb_write(REG_Z, {24'h0, v.z});
        bp_tbl[N_BP-1] = v;
        wb_read(REG_STATUS, rd);
        check_status("status pending", 3'd1, {2'b0, rd[3]});
        check_status("status count", 3'd4, rd[6:4]);

        for (i = 0; i < N_BP; i++) begin
            wait_status_bit(1, 1'b1, "result available");
            wb_read(REG_RESULT, rd);
            check_word($sformatf("drained result %0d", i), bp_tbl[i].exp,
                       polar_word_t'(rd[23:0]));
        end
        wait_status_bit(0, 1'b0, "core idle");
        wb_read(REG_STATUS, rd);
        check_status("status count", 3'd0, rd[6:4]);
        check_status("status result available", 3'd0, {2'b0, rd[1]});
        check_status("status full", 3'd0, {2'b0, rd[2]});
        check_status("status pending", 3'd0, {2'b0, rd[3]});
        check_status("status busy", 3'd0, {2'b0, rd[0]});

        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

// ==== verilog.f ====
+incdir+source
source/polar_pkg.sv
source/wb_polar_regs.sv
source/isqrt_unit.sv
source/atan_search.sv
source/result_fifo.sv
source/polar_core.sv
source/polar_top.sv
tests/tb_polar_top.sv
